// File: cpu16.f
+incdir+hdl
hdl/cpu16_isa_pkg.sv
hdl/cpu16_ctrl_pkg.sv
hdl/alu_unit.sv
hdl/program_counter.sv
hdl/register_file.sv
hdl/sequence_control.sv
hdl/cpu16_top.sv
tb/cpu16_assert.sv
tb/cpu16_tb.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpu16_isa_pkg.sv
      - hdl/cpu16_ctrl_pkg.sv
      - hdl/alu_unit.sv
      - hdl/program_counter.sv
      - hdl/register_file.sv
      - hdl/sequence_control.sv
      - hdl/cpu16_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/cpu16_assert.sv
      - tb/cpu16_tb.sv

// File: tb/cpu16_tb.sv
`default_nettype none

`include "cpu16_macros.svh"

module cpu16_tb;

    localparam int PERIOD      = 40;
    localparam int MEM_WORDS   = 1 << `CPU16_ADDR_W;
    localparam int RESET_CYC   = 5;
    localparam int TOTAL_INSNS = 300;                  // Bound over all five programs
    localparam int NUM_TESTS   = 5;
    localparam int WATCHDOG    = (TOTAL_INSNS * 4 + NUM_TESTS * 50) * PERIOD;
    localparam cpu16_isa_pkg::word_t HLT_WORD = 16'hF000;
    localparam cpu16_isa_pkg::word_t RET_WORD = 16'h6000;

    logic Clk;
    logic rst_n;
    logic mem_en, mem_wr, halt;
    cpu16_isa_pkg::addr_t mem_addr;
    cpu16_isa_pkg::word_t mem_rdata, mem_wdata;

    cpu16_isa_pkg::word_t mem [MEM_WORDS];  // Shared instruction and data memory
    cpu16_isa_pkg::addr_t first_addr;       // First bus address after reset
    logic   fetch_seen;
    int     stray_count;                    // Accesses while halted
    int     load_ptr, insn_count, last_cycles;
    int     errors, checks, tests, test_errors;
    integer seed;
    string  test_name;

    cpu16_top DUT (
        .Clk, .rst_n, .mem_rdata, .mem_en, .mem_wr, .mem_addr, .mem_wdata, .halt
    );

    always #(PERIOD / 2) Clk = ~Clk;

    // --------------------
    // Memory model with read data one cycle after enable
    always @(posedge Clk) begin
        if (mem_en && mem_wr) begin
            mem[mem_addr] <= mem_wdata;
        end else if (mem_en) begin
            mem_rdata <= mem[mem_addr];
        end
        if (!rst_n) begin
            fetch_seen  <= 1'b0;
            stray_count <= 0;
        end else if (mem_en) begin
            if (!fetch_seen) begin
                first_addr <= mem_addr;
                fetch_seen <= 1'b1;
            end
            if (halt) stray_count <= stray_count + 1;
        end
    end

    // --------------------
    // Encoding and reference models
    function automatic cpu16_isa_pkg::word_t fill_word(int addr);
        return 16'hF000 | {7'b0, addr[8:0]};  // Runs as HLT if ever fetched
    endfunction

    function automatic cpu16_isa_pkg::word_t reg_form(logic [3:0] op, logic [2:0] d,
                                                      logic [2:0] s2, logic [2:0] s1);
        return {op, d, 2'b00, s2, 1'b0, s1};
    endfunction

    function automatic cpu16_isa_pkg::word_t imm_form(logic [3:0] op, logic [2:0] d,
                                                      logic [8:0] imm);
        return {op, d, imm};
    endfunction

    function automatic cpu16_isa_pkg::word_t branch_form(logic [3:0] op, logic [1:0] cond,
                                                         logic [9:0] low);
        return {op, cond, low};  // Offset for BRD, source-1 field for BRX
    endfunction

    function automatic logic [3:0] alu_code(int k);
        case (k)
            0:       return 4'h9;  // ADD
            1:       return 4'hA;  // SUB
            2:       return 4'hB;  // AND
            3:       return 4'hC;  // OR
            default: return 4'hD;  // XOR
        endcase
    endfunction

    function automatic cpu16_isa_pkg::word_t alu_model(int k, cpu16_isa_pkg::word_t a,
                                                       cpu16_isa_pkg::word_t b);
        case (k)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            default: return a ^ b;
        endcase
    endfunction

    // Condition outcome after SUB of a minus b
    function automatic logic branch_taken(int cond, cpu16_isa_pkg::word_t a,
                                          cpu16_isa_pkg::word_t b);
        case (cond)
            0:       return a == b;                  // Zero difference
            1:       return a != b;
            2:       return $signed(a) < $signed(b); // N != V is signed less-than
            default: return a >= b;                  // No borrow
        endcase
    endfunction

    // --------------------
    // Program loading and run control
    task automatic emit(cpu16_isa_pkg::word_t w);
        mem[load_ptr] = w;
        load_ptr++;
        insn_count++;
    endtask

    task automatic origin(int addr);
        load_ptr = addr;
    endtask

    task automatic begin_test(string name);
        test_name   = name;
        test_errors = errors;
        @(posedge Clk);
        rst_n <= 1'b0;
        @(posedge Clk);                       // Core now held in reset
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = fill_word(a);
        end
        load_ptr   = 0;
        insn_count = 0;
    endtask

    task automatic run_program();
        int limit;
        limit = insn_count * 4 + 20;
        repeat (RESET_CYC - 1) @(posedge Clk);
        checks++;
        if (mem_en !== 1'b0 || mem_wr !== 1'b0 || halt !== 1'b0) begin
            $display("%s: bus or halt active while reset is held", test_name);
            errors++;
        end
        rst_n <= 1'b1;
        last_cycles = 0;
        while (halt !== 1'b1 && last_cycles < limit) begin
            @(negedge Clk);
            last_cycles++;
        end
        if (halt !== 1'b1) begin
            $display("%s: halt never came within %0d cycles", test_name, limit);
            errors++;
        end
    endtask

    task automatic compare(string what, cpu16_isa_pkg::word_t expected,
                           cpu16_isa_pkg::word_t actual);
        checks++;
        if (actual !== expected) begin
            $display("Error %s: %s expected 0x%04h, actual 0x%04h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_word(int addr, cpu16_isa_pkg::word_t expected);
        compare($sformatf("mem[0x%03h]", addr), expected, mem[addr]);
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_errors) begin
            $display("%s: passed", test_name);
        end else begin
            $display("%s: failed with %0d errors", test_name, errors - test_errors);
        end
    endtask

    // --------------------
    // Directed tests
    task automatic test_reset_halt();
        begin_test("reset_halt");
        emit(HLT_WORD);
        run_program();
        repeat (10) @(negedge Clk);           // Stay idle for a while
        compare("first fetch address", 16'h0000, cpu16_isa_pkg::word_t'(first_addr));
        // RESET cycle, three-cycle HLT, then halt seen one cycle later
        compare("cycles to halt", 16'd5, cpu16_isa_pkg::word_t'(last_cycles));
        checks++;
        if (stray_count != 0 || halt !== 1'b1) begin
            $display("%s: memory accessed or halt dropped after HLT", test_name);
            errors++;
        end
        end_test();
    endtask

    task automatic test_load_store();
        begin_test("load_store");
        emit(imm_form(4'h1, 3'd1, 9'h0A5));   // LDI r1
        emit(imm_form(4'h1, 3'd2, 9'h15A));   // LDI r2
        emit(imm_form(4'h3, 3'd1, 9'h100));   // ST r1
        emit(imm_form(4'h3, 3'd2, 9'h101));
        emit(imm_form(4'h2, 3'd3, 9'h100));   // LD r3
        emit(imm_form(4'h2, 3'd4, 9'h101));   // LD r4
        emit(imm_form(4'h3, 3'd4, 9'h102));
        emit(imm_form(4'h3, 3'd3, 9'h103));
        emit(imm_form(4'h1, 3'd5, 9'h120));   // Pointer for STX
        emit(reg_form(4'h4, 3'd0, 3'd5, 3'd2)); // STX data r2 to address r5
        emit(HLT_WORD);
        run_program();
        check_word(9'h100, 16'h00A5);
        check_word(9'h101, 16'h015A);
        check_word(9'h102, 16'h015A);
        check_word(9'h103, 16'h00A5);
        check_word(9'h120, 16'h015A);
        end_test();
    endtask

    task automatic test_alu();
        logic [8:0] op_a [4];
        logic [8:0] op_b [4];
        begin_test("alu_random");
        for (int r = 0; r < 4; r++) begin
            op_a[r] = 9'($random(seed));
            op_b[r] = 9'($random(seed));
            emit(imm_form(4'h1, 3'd1, op_a[r]));
            emit(imm_form(4'h1, 3'd2, op_b[r]));
            for (int k = 0; k < 5; k++) begin
                emit(reg_form(alu_code(k), 3'd3, 3'd2, 3'd1)); // r3 = r1 op r2
                emit(imm_form(4'h3, 3'd3, 9'(9'h140 + r * 8 + k)));
            end
        end
        emit(HLT_WORD);
        run_program();
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 5; k++) begin
                check_word(9'h140 + r * 8 + k, alu_model(k, 16'(op_a[r]), 16'(op_b[r])));
            end
        end
        end_test();
    endtask

    // Taken branch skips the not-taken marker store while the join marker always runs
    task automatic test_branches();
        logic [8:0] a, b;
        int idx;
        begin_test("branches");
        emit(imm_form(4'h1, 3'd6, 9'h0C3));   // Not-taken marker
        emit(imm_form(4'h1, 3'd7, 9'h13C));   // Join marker
        for (int x = 0; x < 2; x++) begin
            for (int c = 0; c < 4; c++) begin
                for (int i = 0; i < 3; i++) begin
                    idx = (x * 4 + c) * 3 + i;
                    a   = (i == 2) ? 9'd3 : ((i == 1) ? 9'd7 : 9'd5);
                    b   = (i == 0) ? 9'd5 : ((i == 1) ? 9'd3 : 9'd7);
                    emit(imm_form(4'h1, 3'd1, a));
                    emit(imm_form(4'h1, 3'd2, b));
                    if (x == 1) emit(imm_form(4'h1, 3'd5, 9'(load_ptr + 4)));
                    emit(reg_form(4'hA, 3'd3, 3'd2, 3'd1)); // SUB sets the flags
                    if (x == 0) emit(branch_form(4'h7, 2'(c), 10'd1));
                    else        emit(branch_form(4'h8, 2'(c), 10'd5));
                    emit(imm_form(4'h3, 3'd6, 9'(9'h180 + 2 * idx)));
                    emit(imm_form(4'h3, 3'd7, 9'(9'h181 + 2 * idx)));
                end
            end
        end
        emit(HLT_WORD);
        run_program();
        for (int x = 0; x < 2; x++) begin
            for (int c = 0; c < 4; c++) begin
                for (int i = 0; i < 3; i++) begin
                    idx = (x * 4 + c) * 3 + i;
                    a   = (i == 2) ? 9'd3 : ((i == 1) ? 9'd7 : 9'd5);
                    b   = (i == 0) ? 9'd5 : ((i == 1) ? 9'd3 : 9'd7);
                    check_word(9'h180 + 2 * idx, branch_taken(c, 16'(a), 16'(b))
                               ? fill_word(9'h180 + 2 * idx) : 16'h00C3);
                    check_word(9'h181 + 2 * idx, 16'h013C);
                end
            end
        end
        end_test();
    endtask

    // r7 counts steps, so each marker shows its place in the order
    task automatic test_calls();
        begin_test("call_return");
        emit(imm_form(4'h1, 3'd1, 9'h040));   // Subroutine address
        emit(imm_form(4'h1, 3'd5, 9'h060));   // JMP target
        emit(imm_form(4'h1, 3'd6, 9'h001));
        emit(imm_form(4'h1, 3'd7, 9'h000));
        emit(reg_form(4'h5, 3'b000, 3'd0, 3'd1)); // JPL r1 linking address 5
        emit(reg_form(4'h9, 3'd7, 3'd6, 3'd7));
        emit(imm_form(4'h3, 3'd7, 9'h1C2));
        emit(HLT_WORD);
        origin(9'h040);
        emit(reg_form(4'h9, 3'd7, 3'd6, 3'd7));
        emit(imm_form(4'h3, 3'd7, 9'h1C0));
        emit(reg_form(4'h5, 3'b100, 3'd0, 3'd5)); // JMP r5 keeping the link
        emit(imm_form(4'h3, 3'd6, 9'h1C3));   // Reached only if JMP linked
        emit(HLT_WORD);
        origin(9'h060);
        emit(reg_form(4'h9, 3'd7, 3'd6, 3'd7));
        emit(imm_form(4'h3, 3'd7, 9'h1C1));
        emit(RET_WORD);
        run_program();
        check_word(9'h1C0, 16'd1);
        check_word(9'h1C1, 16'd2);
        check_word(9'h1C2, 16'd3);
        check_word(9'h1C3, fill_word(9'h1C3));
        end_test();
    endtask

    // --------------------
    initial begin
        Clk       = 1'b0;
        rst_n     = 1'b0;
        mem_rdata = '0;
        seed      = 50;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        test_reset_halt();
        test_load_store();
        test_alu();
        test_branches();
        test_calls();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog sized from the instruction budget
    initial begin
        #(WATCHDOG);
        $display("Watchdog expired before all tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/cpu16_assert.sv
`default_nettype none

module cpu16_seq_assert (
    input logic                       Clk,
    input logic                       rst_n,
    input cpu16_ctrl_pkg::seq_state_e state,
    input logic                       mem_en,
    input logic                       mem_wr,
    input logic                       reg_we,
    input logic                       pc_ld,
    input logic                       pc_inc,
    input logic                       halt
);

    // --------------------
    // Bus and sequencer rules
    a_wr_needs_en: assert property (@(posedge Clk) disable iff (!rst_n) mem_wr |-> mem_en)
        else $error("mem_wr high without mem_en");

    a_halt_quiet: assert property (@(posedge Clk) disable iff (!rst_n) halt |-> !mem_en && !reg_we)
        else $error("memory or register activity while halted");

    a_pc_one_src: assert property (@(posedge Clk) disable iff (!rst_n) !(pc_ld && pc_inc))
        else $error("pc_ld and pc_inc high together");

    a_state_legal: assert property (@(posedge Clk) disable iff (!rst_n)
        state inside {cpu16_ctrl_pkg::IDLE, cpu16_ctrl_pkg::RESET, cpu16_ctrl_pkg::FETCH_ADDR,
                      cpu16_ctrl_pkg::FETCH_IR, cpu16_ctrl_pkg::DECODE, cpu16_ctrl_pkg::EXECUTE})
        else $error("sequencer in an undefined state");

endmodule

bind sequence_control cpu16_seq_assert u_seq_assert (
    .Clk, .rst_n, .state, .mem_en, .mem_wr, .reg_we, .pc_ld, .pc_inc, .halt
);

`default_nettype wire

// File: hdl/cpu16_top.sv
`default_nettype none

module cpu16_top (
    input  logic                 Clk,
    input  logic                 rst_n,
    input  cpu16_isa_pkg::word_t mem_rdata,
    output logic                 mem_en,
    output logic                 mem_wr,
    output cpu16_isa_pkg::addr_t mem_addr,
    output cpu16_isa_pkg::word_t mem_wdata,
    output logic                 halt
);

    // --------------------
    // Control and data nets
    cpu16_isa_pkg::word_t      ir;
    cpu16_isa_pkg::word_t      src1_data;
    cpu16_isa_pkg::word_t      src2_data;
    cpu16_isa_pkg::word_t      alu_result;
    cpu16_isa_pkg::addr_t      pc;
    cpu16_ctrl_pkg::flags_t    flags;
    cpu16_ctrl_pkg::pc_src_e   pc_src;
    cpu16_ctrl_pkg::addr_src_e addr_src;
    cpu16_ctrl_pkg::data_src_e data_src;
    cpu16_ctrl_pkg::alu_op_e   alu_op;
    logic pc_clr, pc_inc, pc_ld, stk_ld, bra_sel;
    logic reg_we, src1_sel, alu_ld, flg_ld, flg_clr;

    sequence_control u_seq (
        .Clk, .rst_n, .mem_rdata, .flags, .ir,
        .pc_clr, .pc_inc, .pc_ld, .pc_src, .stk_ld, .bra_sel,
        .mem_en, .mem_wr, .addr_src,
        .reg_we, .data_src, .src1_sel,
        .alu_op, .alu_ld, .flg_ld, .flg_clr, .halt
    );

    program_counter u_pc (
        .Clk, .rst_n,
        .clr (pc_clr),
        .inc (pc_inc),
        .ld  (pc_ld),
        .pc_src, .stk_ld, .bra_sel, .ir, .src1_data, .pc
    );

    register_file u_rf (
        .Clk, .rst_n, .ir, .src1_sel,
        .we  (reg_we),
        .data_src, .mem_rdata, .alu_result, .src1_data, .src2_data
    );

    alu_unit u_alu (
        .Clk, .rst_n,
        .op     (alu_op),
        .alu_ld, .flg_ld, .flg_clr,
        .a      (src1_data),
        .b      (src2_data),
        .result (alu_result),
        .flags
    );

    // Memory address mux
    always_comb begin
        case (addr_src)
            cpu16_ctrl_pkg::ADDR_IMM: mem_addr = cpu16_isa_pkg::addr_t'(cpu16_isa_pkg::imm_of(ir));
            cpu16_ctrl_pkg::ADDR_REG: mem_addr = cpu16_isa_pkg::addr_t'(src2_data); // STX
            default:                  mem_addr = pc;
        endcase
    end

    assign mem_wdata = src1_data; // ST and STX data

endmodule

`default_nettype wire

// File: hdl/sequence_control.sv
`default_nettype none

module sequence_control (
    input  logic                      Clk,
    input  logic                      rst_n,
    input  cpu16_isa_pkg::word_t      mem_rdata,
    input  cpu16_ctrl_pkg::flags_t    flags,
    output cpu16_isa_pkg::word_t      ir,
    // Program counter
    output logic                      pc_clr,
    output logic                      pc_inc,
    output logic                      pc_ld,
    output cpu16_ctrl_pkg::pc_src_e   pc_src,
    output logic                      stk_ld,
    output logic                      bra_sel,
    // Memory
    output logic                      mem_en,
    output logic                      mem_wr,
    output cpu16_ctrl_pkg::addr_src_e addr_src,
    // Register file
    output logic                      reg_we,
    output cpu16_ctrl_pkg::data_src_e data_src,
    output logic                      src1_sel,
    // ALU
    output cpu16_ctrl_pkg::alu_op_e   alu_op,
    output logic                      alu_ld,
    output logic                      flg_ld,
    output logic                      flg_clr,
    output logic                      halt
);

    cpu16_ctrl_pkg::seq_state_e state;
    cpu16_ctrl_pkg::seq_state_e next_state;
    cpu16_isa_pkg::opcode_e     opcode;
    logic                       take_branch;

    assign opcode = cpu16_isa_pkg::opcode_of(ir);
    assign halt   = (state == cpu16_ctrl_pkg::IDLE); // Only HLT reaches IDLE

    // --------------------
    // State and IR registers
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpu16_ctrl_pkg::RESET;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge Clk) begin
        if (state == cpu16_ctrl_pkg::FETCH_IR) begin
            ir <= mem_rdata; // Word requested in FETCH_ADDR
        end
    end

    // --------------------
    // Branch condition against current flags
    always_comb begin
        take_branch = 1'b0;
        case (cpu16_isa_pkg::cond_of(ir))
            cpu16_isa_pkg::EQ: take_branch = flags.z;
            cpu16_isa_pkg::NE: take_branch = !flags.z;
            cpu16_isa_pkg::LT: take_branch = flags.n ^ flags.v;
            cpu16_isa_pkg::CS: take_branch = flags.c;
            default:           take_branch = 1'b0;
        endcase
    end

    // ALU op straight from the opcode, sampled by alu_ld in DECODE
    always_comb begin
        case (opcode)
            cpu16_isa_pkg::SUB: alu_op = cpu16_ctrl_pkg::ALU_SUB;
            cpu16_isa_pkg::AND: alu_op = cpu16_ctrl_pkg::ALU_AND;
            cpu16_isa_pkg::OR:  alu_op = cpu16_ctrl_pkg::ALU_OR;
            cpu16_isa_pkg::XOR: alu_op = cpu16_ctrl_pkg::ALU_XOR;
            default:            alu_op = cpu16_ctrl_pkg::ALU_ADD;
        endcase
    end

    // --------------------
    // Next state and control strobes
    always_comb begin
        next_state = state;
        pc_clr     = 1'b0;
        pc_inc     = 1'b0;
        pc_ld      = 1'b0;
        pc_src     = cpu16_ctrl_pkg::PC_BRANCH;
        stk_ld     = 1'b0;
        bra_sel    = 1'b0;
        mem_en     = 1'b0;
        mem_wr     = 1'b0;
        addr_src   = cpu16_ctrl_pkg::ADDR_PC;
        reg_we     = 1'b0;
        data_src   = cpu16_ctrl_pkg::DATA_IMM;
        src1_sel   = 1'b1;                         // Source-1 field by default
        alu_ld     = 1'b0;
        flg_ld     = 1'b0;
        flg_clr    = 1'b0;

        case (state)
            cpu16_ctrl_pkg::IDLE: begin
                next_state = cpu16_ctrl_pkg::IDLE; // Stuck until reset
            end

            cpu16_ctrl_pkg::RESET: begin
                pc_clr     = 1'b1;
                next_state = cpu16_ctrl_pkg::FETCH_ADDR;
            end

            cpu16_ctrl_pkg::FETCH_ADDR: begin
                mem_en     = 1'b1;                 // Read at PC
                next_state = cpu16_ctrl_pkg::FETCH_IR;
            end

            cpu16_ctrl_pkg::FETCH_IR: begin
                pc_inc     = 1'b1;                 // IR loads on this edge too
                next_state = cpu16_ctrl_pkg::DECODE;
            end

            cpu16_ctrl_pkg::DECODE: begin
                next_state = cpu16_ctrl_pkg::FETCH_ADDR;
                case (opcode)
                    cpu16_isa_pkg::HLT: next_state = cpu16_ctrl_pkg::IDLE;
                    cpu16_isa_pkg::LDI: reg_we = 1'b1; // Immediate into dest
                    cpu16_isa_pkg::LD: begin
                        mem_en     = 1'b1;
                        addr_src   = cpu16_ctrl_pkg::ADDR_IMM;
                        next_state = cpu16_ctrl_pkg::EXECUTE;
                    end
                    cpu16_isa_pkg::ST: begin
                        mem_en   = 1'b1;
                        mem_wr   = 1'b1;
                        addr_src = cpu16_ctrl_pkg::ADDR_IMM;
                        src1_sel = 1'b0;           // Data from dest field
                    end
                    cpu16_isa_pkg::STX: begin
                        mem_en   = 1'b1;
                        mem_wr   = 1'b1;
                        addr_src = cpu16_ctrl_pkg::ADDR_REG; // Address in source 2
                    end
                    cpu16_isa_pkg::JPL: begin
                        pc_ld  = 1'b1;
                        pc_src = cpu16_ctrl_pkg::PC_REG;
                        stk_ld = !cpu16_isa_pkg::no_link(ir); // JMP leaves link
                    end
                    cpu16_isa_pkg::RET: begin
                        pc_ld  = 1'b1;
                        pc_src = cpu16_ctrl_pkg::PC_LINK;
                    end
                    cpu16_isa_pkg::BRD, cpu16_isa_pkg::BRX: begin
                        pc_ld   = take_branch;
                        bra_sel = (opcode == cpu16_isa_pkg::BRD); // Offset vs register
                        flg_clr = 1'b1;            // Flags consumed either way
                    end
                    cpu16_isa_pkg::ADD, cpu16_isa_pkg::SUB, cpu16_isa_pkg::AND,
                    cpu16_isa_pkg::OR, cpu16_isa_pkg::XOR: begin
                        alu_ld     = 1'b1;
                        flg_ld     = 1'b1;
                        next_state = cpu16_ctrl_pkg::EXECUTE;
                    end
                    default: ;                     // NOP and code E
                endcase
            end

            cpu16_ctrl_pkg::EXECUTE: begin
                reg_we     = 1'b1;                 // Write-back into dest
                data_src   = (opcode == cpu16_isa_pkg::LD) ? cpu16_ctrl_pkg::DATA_MEM
                                                           : cpu16_ctrl_pkg::DATA_ALU;
                next_state = cpu16_ctrl_pkg::FETCH_ADDR;
            end

            default: next_state = cpu16_ctrl_pkg::RESET; // Recover from a bad encoding
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`default_nettype none

`include "cpu16_macros.svh"

module register_file (
    input  logic                      Clk,
    input  logic                      rst_n,
    input  cpu16_isa_pkg::word_t      ir,
    input  logic                      src1_sel,
    input  logic                      we,
    input  cpu16_ctrl_pkg::data_src_e data_src,
    input  cpu16_isa_pkg::word_t      mem_rdata,
    input  cpu16_isa_pkg::word_t      alu_result,
    output cpu16_isa_pkg::word_t      src1_data,
    output cpu16_isa_pkg::word_t      src2_data
);

    cpu16_isa_pkg::word_t     regs [`CPU16_NUM_REGS];
    cpu16_isa_pkg::word_t     wr_data;
    cpu16_isa_pkg::reg_idx_t  src1_idx;

    // ST reads its data register through the dest field
    assign src1_idx  = src1_sel ? cpu16_isa_pkg::src1_of(ir) : cpu16_isa_pkg::dest_of(ir);
    assign src1_data = regs[src1_idx];
    assign src2_data = regs[cpu16_isa_pkg::src2_of(ir)];

    always_comb begin
        case (data_src)
            cpu16_ctrl_pkg::DATA_MEM: wr_data = mem_rdata;
            cpu16_ctrl_pkg::DATA_ALU: wr_data = alu_result;
            default:                  wr_data = cpu16_isa_pkg::imm_of(ir); // LDI
        endcase
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU16_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[cpu16_isa_pkg::dest_of(ir)] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/program_counter.sv
`default_nettype none

`include "cpu16_macros.svh"

module program_counter (
    input  logic                    Clk,
    input  logic                    rst_n,
    input  logic                    clr,
    input  logic                    inc,
    input  logic                    ld,
    input  cpu16_ctrl_pkg::pc_src_e pc_src,
    input  logic                    stk_ld,
    input  logic                    bra_sel,
    input  cpu16_isa_pkg::word_t    ir,
    input  cpu16_isa_pkg::word_t    src1_data,
    output cpu16_isa_pkg::addr_t    pc
);

    cpu16_isa_pkg::addr_t link;   // One-entry call stack
    cpu16_isa_pkg::addr_t reg_tgt;
    cpu16_isa_pkg::addr_t bra_tgt;
    cpu16_isa_pkg::addr_t next_pc;
    logic [`CPU16_BRA_OFF_W-1:0] bra_sum;

    assign reg_tgt = cpu16_isa_pkg::addr_t'(src1_data);

    // Incremented PC plus offset wrapping at 512 words
    assign bra_sum = `CPU16_BRA_OFF_W'(pc) + cpu16_isa_pkg::bra_off_of(ir);
    assign bra_tgt = bra_sel ? bra_sum[`CPU16_ADDR_W-1:0] : reg_tgt;

    always_comb begin
        case (pc_src)
            cpu16_ctrl_pkg::PC_LINK: next_pc = link;
            cpu16_ctrl_pkg::PC_REG:  next_pc = reg_tgt;
            default:                 next_pc = bra_tgt;
        endcase
    end

    // --------------------
    // Clear, then load, then increment
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            pc   <= '0;
            link <= '0;
        end else begin
            if (clr)      pc <= '0;
            else if (ld)  pc <= next_pc;
            else if (inc) pc <= pc + 1'b1;
            if (stk_ld)   link <= pc;   // Return address saved on the jump edge
        end
    end

endmodule

`default_nettype wire

// File: hdl/alu_unit.sv
`default_nettype none

`include "cpu16_macros.svh"

module alu_unit (
    input  logic                    Clk,
    input  logic                    rst_n,
    input  cpu16_ctrl_pkg::alu_op_e op,
    input  logic                    alu_ld,
    input  logic                    flg_ld,
    input  logic                    flg_clr,
    input  cpu16_isa_pkg::word_t    a,   // Source 1
    input  cpu16_isa_pkg::word_t    b,   // Source 2
    output cpu16_isa_pkg::word_t    result,
    output cpu16_ctrl_pkg::flags_t  flags
);

    localparam int MSB = `CPU16_DATA_W - 1;

    logic [`CPU16_DATA_W:0] sum;        // Extra bit for carry out
    cpu16_isa_pkg::word_t   res;
    cpu16_ctrl_pkg::flags_t nxt_flags;

    // --------------------
    // Combinational ALU
    always_comb begin
        sum         = '0;
        nxt_flags.c = 1'b0;             // Logic ops leave C and V clear
        nxt_flags.v = 1'b0;
        case (op)
            cpu16_ctrl_pkg::ALU_ADD: begin
                sum         = {1'b0, a} + {1'b0, b};
                res         = sum[MSB:0];
                nxt_flags.c = sum[`CPU16_DATA_W];
                nxt_flags.v = (a[MSB] == b[MSB]) && (res[MSB] != a[MSB]);
            end
            cpu16_ctrl_pkg::ALU_SUB: begin
                sum         = {1'b0, a} + {1'b0, ~b} + 1'b1; // Two's complement
                res         = sum[MSB:0];
                nxt_flags.c = sum[`CPU16_DATA_W];            // Set when a >= b
                nxt_flags.v = (a[MSB] != b[MSB]) && (res[MSB] != a[MSB]);
            end
            cpu16_ctrl_pkg::ALU_AND: res = a & b;
            cpu16_ctrl_pkg::ALU_OR:  res = a | b;
            cpu16_ctrl_pkg::ALU_XOR: res = a ^ b;
            default:                 res = '0;
        endcase
        nxt_flags.z = (res == '0);
        nxt_flags.n = res[MSB];
    end

    // Result register
    always_ff @(posedge Clk) begin
        if (alu_ld) begin
            result <= res;
        end
    end

    // Flag register where clear wins over load
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (flg_clr) begin
            flags <= '0;
        end else if (flg_ld) begin
            flags <= nxt_flags;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpu16_ctrl_pkg.sv
`default_nettype none

`include "cpu16_macros.svh"

package cpu16_ctrl_pkg;

    // Sequencer states
    typedef enum logic [`CPU16_STATE_W-1:0] {
        IDLE       = 3'd0, // Halted
        RESET      = 3'd1, // Clear PC
        FETCH_ADDR = 3'd2, // PC onto the bus
        FETCH_IR   = 3'd3, // Capture IR, bump PC
        DECODE     = 3'd4,
        EXECUTE    = 3'd5  // Write-back for LD and ALU ops
    } seq_state_e;

    typedef enum logic [`CPU16_ALU_OP_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR
    } alu_op_e;

    // Next-PC source
    typedef enum logic [`CPU16_SEL_W-1:0] {
        PC_BRANCH, PC_LINK, PC_REG
    } pc_src_e;

    // Memory address source
    typedef enum logic [`CPU16_SEL_W-1:0] {
        ADDR_PC, ADDR_IMM, ADDR_REG
    } addr_src_e;

    // Register write-back source
    typedef enum logic [`CPU16_SEL_W-1:0] {
        DATA_IMM, DATA_MEM, DATA_ALU
    } data_src_e;

    typedef struct packed {
        logic z; // Zero
        logic c; // Carry, or no borrow on SUB
        logic n; // Sign
        logic v; // Signed overflow
    } flags_t;

endpackage

`default_nettype wire

// File: hdl/cpu16_isa_pkg.sv
`default_nettype none

`include "cpu16_macros.svh"

package cpu16_isa_pkg;

    typedef logic [`CPU16_DATA_W-1:0]    word_t;
    typedef logic [`CPU16_ADDR_W-1:0]    addr_t;
    typedef logic [`CPU16_REG_IDX_W-1:0] reg_idx_t;

    // Opcode in ir[15:12] with unused code E running as NOP
    typedef enum logic [`CPU16_OPCODE_W-1:0] {
        NOP = 4'h0, LDI = 4'h1, LD  = 4'h2, ST  = 4'h3,
        STX = 4'h4, JPL = 4'h5, RET = 4'h6, BRD = 4'h7,
        BRX = 4'h8, ADD = 4'h9, SUB = 4'hA, AND = 4'hB,
        OR  = 4'hC, XOR = 4'hD, HLT = 4'hF
    } opcode_e;

    // Branch condition in ir[11:10]
    typedef enum logic [`CPU16_COND_W-1:0] {
        EQ = 2'b00, // Z set
        NE = 2'b01, // Z clear
        LT = 2'b10, // N != V
        CS = 2'b11  // C set
    } branch_cond_e;

    // --------------------
    // Field extraction
    function automatic opcode_e opcode_of(word_t ir);
        return opcode_e'(ir[15:12]);
    endfunction

    function automatic branch_cond_e cond_of(word_t ir);
        return branch_cond_e'(ir[11:10]);
    endfunction

    function automatic reg_idx_t dest_of(word_t ir);
        return ir[11:9];
    endfunction

    function automatic reg_idx_t src1_of(word_t ir);
        return ir[2:0];
    endfunction

    function automatic reg_idx_t src2_of(word_t ir);
        return ir[6:4];
    endfunction

    // Zero-extended immediate or absolute address
    function automatic word_t imm_of(word_t ir);
        return word_t'(ir[`CPU16_IMM_W-1:0]);
    endfunction

    function automatic logic [`CPU16_BRA_OFF_W-1:0] bra_off_of(word_t ir);
        return ir[`CPU16_BRA_OFF_W-1:0];
    endfunction

    function automatic logic no_link(word_t ir); // 1 means plain JMP
        return ir[11];
    endfunction

endpackage

`default_nettype wire

// File: hdl/cpu16_macros.svh
`ifndef CPU16_MACROS_SVH
`define CPU16_MACROS_SVH

// Datapath sizes
`define CPU16_DATA_W     16 // Data and instruction word
`define CPU16_ADDR_W     9  // Word address over 512 words
`define CPU16_NUM_REGS   8  // General registers
`define CPU16_REG_IDX_W  3  // Register index field

// Instruction fields
`define CPU16_OPCODE_W   4
`define CPU16_COND_W     2
`define CPU16_IMM_W      9  // Immediate / absolute address
`define CPU16_BRA_OFF_W  10 // Signed branch offset

// Datapath control encodings
`define CPU16_STATE_W    3
`define CPU16_ALU_OP_W   3
`define CPU16_SEL_W      2  // Width of the 3-way mux selects

`endif
